//--- rtl/riscv_alu_pkg.sv
`default_nettype none

package riscv_alu_pkg;

	localparam int ALU_OP_WIDTH = 7;
	localparam int XLEN = 32;
	localparam int CNT_WIDTH = 6;

	// for divisions bit 0 marks signed and bit 1 selects the remainder.
	typedef enum logic [ALU_OP_WIDTH-1:0] {
		ALU_LTS   = 7'b0000000,
		ALU_LTU   = 7'b0000001,
		ALU_SLTS  = 7'b0000010,
		ALU_SLTU  = 7'b0000011,
		ALU_LES   = 7'b0000100,
		ALU_LEU   = 7'b0000101,
		ALU_SLETS = 7'b0000110,
		ALU_SLETU = 7'b0000111,
		ALU_GTS   = 7'b0001000,
		ALU_GTU   = 7'b0001001,
		ALU_GES   = 7'b0001010,
		ALU_GEU   = 7'b0001011,
		ALU_EQ    = 7'b0001100,
		ALU_NE    = 7'b0001101,
		ALU_MIN   = 7'b0010000,
		ALU_MINU  = 7'b0010001,
		ALU_MAX   = 7'b0010010,
		ALU_MAXU  = 7'b0010011,
		ALU_AND   = 7'b0010101,
		ALU_ADD   = 7'b0011000,
		ALU_SUB   = 7'b0011001,
		ALU_SRA   = 7'b0100100,
		ALU_SRL   = 7'b0100101,
		ALU_ROR   = 7'b0100110,
		ALU_SLL   = 7'b0100111,
		ALU_OR    = 7'b0101110,
		ALU_XOR   = 7'b0101111,
		ALU_DIVU  = 7'b0110000,
		ALU_DIV   = 7'b0110001,
		ALU_REMU  = 7'b0110010,
		ALU_REM   = 7'b0110011,
		ALU_CNT   = 7'b0110100,
		ALU_CLB   = 7'b0110101,
		ALU_FF1   = 7'b0110110,
		ALU_FL1   = 7'b0110111
	} alu_op_e;

	typedef struct packed {
		alu_op_e op;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
	} alu_req_t;

	typedef enum logic [1:0] {
		IDLE = 2'b00,
		BUSY = 2'b01,
		DONE = 2'b10
	} div_state_e;

endpackage

`default_nettype wire

//--- rtl/riscv_alu_arith.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_alu_arith (
	input  riscv_alu_pkg::alu_req_t      req_i,
	output logic [riscv_alu_pkg::XLEN-1:0] sum_o,
	output logic                         cmp_true_o,
	output logic [riscv_alu_pkg::XLEN-1:0] minmax_o
);

	logic                          sub;
	logic [riscv_alu_pkg::XLEN-1:0] op_b;
	logic                          cmp_signed;
	logic                          is_equal;
	logic                          is_greater;
	logic                          do_min;

	// subtract is a + ~b + 1.
	assign sub   = (req_i.op == riscv_alu_pkg::ALU_SUB);
	assign op_b  = sub ? ~req_i.b : req_i.b;
	assign sum_o = req_i.a + op_b + {{(riscv_alu_pkg::XLEN-1){1'b0}}, sub};

	always_comb begin
		cmp_signed = 1'b0;
		case (req_i.op)
			riscv_alu_pkg::ALU_LTS, riscv_alu_pkg::ALU_SLTS,
			riscv_alu_pkg::ALU_LES, riscv_alu_pkg::ALU_SLETS,
			riscv_alu_pkg::ALU_GTS, riscv_alu_pkg::ALU_GES,
			riscv_alu_pkg::ALU_MIN, riscv_alu_pkg::ALU_MAX:
				cmp_signed = 1'b1;
			default: ;
		endcase
	end

	// one extra bit turns the unsigned compare into a signed one.
	assign is_equal   = (req_i.a == req_i.b);
	assign is_greater = $signed({cmp_signed & req_i.a[riscv_alu_pkg::XLEN-1], req_i.a}) >
		$signed({cmp_signed & req_i.b[riscv_alu_pkg::XLEN-1], req_i.b});

	always_comb begin
		cmp_true_o = is_equal;
		case (req_i.op)
			riscv_alu_pkg::ALU_EQ:
				cmp_true_o = is_equal;
			riscv_alu_pkg::ALU_NE:
				cmp_true_o = ~is_equal;
			riscv_alu_pkg::ALU_GTS, riscv_alu_pkg::ALU_GTU:
				cmp_true_o = is_greater;
			riscv_alu_pkg::ALU_GES, riscv_alu_pkg::ALU_GEU:
				cmp_true_o = is_greater | is_equal;
			riscv_alu_pkg::ALU_LTS, riscv_alu_pkg::ALU_LTU,
			riscv_alu_pkg::ALU_SLTS, riscv_alu_pkg::ALU_SLTU:
				cmp_true_o = ~(is_greater | is_equal);
			riscv_alu_pkg::ALU_LES, riscv_alu_pkg::ALU_LEU,
			riscv_alu_pkg::ALU_SLETS, riscv_alu_pkg::ALU_SLETU:
				cmp_true_o = ~is_greater;
			default: ;
		endcase
	end

	// max keeps a when a is greater, min flips the choice.
	assign do_min   = (req_i.op == riscv_alu_pkg::ALU_MIN) ||
		(req_i.op == riscv_alu_pkg::ALU_MINU);
	assign minmax_o = (is_greater ^ do_min) ? req_i.a : req_i.b;

endmodule

`default_nettype wire

//--- rtl/riscv_alu_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_alu_shifter (
	input  riscv_alu_pkg::alu_req_t      req_i,
	output logic [riscv_alu_pkg::XLEN-1:0] shift_result_o
);

	logic                            shift_left;
	logic                            shift_arith;
	logic                            rotate;
	logic [riscv_alu_pkg::XLEN-1:0]   op_a_rev;
	logic [riscv_alu_pkg::XLEN-1:0]   op_a;
	logic [riscv_alu_pkg::XLEN-1:0]   fill;
	logic [2*riscv_alu_pkg::XLEN-1:0] wide;
	logic [2*riscv_alu_pkg::XLEN-1:0] wide_shifted;
	logic [riscv_alu_pkg::XLEN-1:0]   right_result;
	logic [riscv_alu_pkg::XLEN-1:0]   right_rev;

	assign shift_left  = (req_i.op == riscv_alu_pkg::ALU_SLL);
	assign shift_arith = (req_i.op == riscv_alu_pkg::ALU_SRA);
	assign rotate      = (req_i.op == riscv_alu_pkg::ALU_ROR);

	// a left shift is a right shift of the reversed word.
	assign op_a_rev = {<<{req_i.a}};
	assign op_a     = shift_left ? op_a_rev : req_i.a;

	// upper word is the sign fill, or a second copy for rotate.
	assign fill = rotate ? op_a :
		{riscv_alu_pkg::XLEN{shift_arith & op_a[riscv_alu_pkg::XLEN-1]}};
	assign wide = {fill, op_a};

	assign wide_shifted = wide >> req_i.b[4:0];
	assign right_result = wide_shifted[riscv_alu_pkg::XLEN-1:0];
	assign right_rev    = {<<{right_result}};

	assign shift_result_o = shift_left ? right_rev : right_result;

endmodule

`default_nettype wire

//--- rtl/riscv_alu_bit_count.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_alu_bit_count (
	input  riscv_alu_pkg::alu_req_t           req_i,
	input  logic [riscv_alu_pkg::XLEN-1:0]      count_in_i,
	output logic [riscv_alu_pkg::CNT_WIDTH-1:0] count_result_o,
	output logic [4:0]                        first_one_o,
	output logic                              no_ones_o
);

	logic [riscv_alu_pkg::CNT_WIDTH-1:0] popcnt;
	logic [riscv_alu_pkg::CNT_WIDTH-1:0] ff1_idx;
	logic [riscv_alu_pkg::CNT_WIDTH-1:0] fl1_idx;
	logic [riscv_alu_pkg::CNT_WIDTH-1:0] clb_idx;
	logic [4:0]                         first_one;

	always_comb begin
		popcnt = '0;
		for (int i = 0; i < riscv_alu_pkg::XLEN; i++) begin
			popcnt = popcnt + riscv_alu_pkg::CNT_WIDTH'(req_i.a[i]);
		end
	end

	// priority scan from the top, so the lowest set bit wins.
	always_comb begin
		first_one = '0;
		for (int i = riscv_alu_pkg::XLEN - 1; i >= 0; i--) begin
			if (count_in_i[i]) begin
				first_one = 5'(i);
			end
		end
	end

	assign no_ones_o   = ~|count_in_i;
	assign first_one_o = first_one;

	assign ff1_idx = {1'b0, first_one};
	assign fl1_idx = riscv_alu_pkg::CNT_WIDTH'(31) - ff1_idx;
	assign clb_idx = ff1_idx - riscv_alu_pkg::CNT_WIDTH'(1);

	always_comb begin
		count_result_o = '0;
		case (req_i.op)
			riscv_alu_pkg::ALU_FF1:
				count_result_o = no_ones_o ? riscv_alu_pkg::CNT_WIDTH'(32) : ff1_idx;
			riscv_alu_pkg::ALU_FL1:
				count_result_o = no_ones_o ? riscv_alu_pkg::CNT_WIDTH'(32) : fl1_idx;
			riscv_alu_pkg::ALU_CNT:
				count_result_o = popcnt;
			riscv_alu_pkg::ALU_CLB: begin
				if (!no_ones_o) begin
					count_result_o = clb_idx;
				end else if (req_i.a[riscv_alu_pkg::XLEN-1]) begin
					count_result_o = riscv_alu_pkg::CNT_WIDTH'(31);
				end else begin
					count_result_o = '0;
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/riscv_alu_div.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_alu_div #(
	parameter int WIDTH = 32
) (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    div_start_i,
	input  riscv_alu_pkg::alu_req_t req_i,
	input  logic [4:0]              first_one_i,
	input  logic                    no_ones_i,
	input  logic                    out_ready_i,
	output logic [WIDTH-1:0]        div_result_o,
	output logic                    div_done_o
);

	localparam int CW = $clog2(WIDTH) + 1;

	riscv_alu_pkg::div_state_e state_q;
	logic [CW-1:0]    cnt_q;
	logic [CW-1:0]    steps;
	logic [CW-1:0]    shift;
	logic             neg_a;
	logic             neg_b;
	logic [WIDTH-1:0] mag_a;
	logic [WIDTH-1:0] mag_b;
	logic [WIDTH-1:0] dvd_q;
	logic [WIDTH-1:0] dvs_q;
	logic [WIDTH-1:0] rem_q;
	logic [WIDTH-1:0] quo_q;
	logic             neg_quo_q;
	logic             neg_rem_q;
	logic             zero_q;
	logic             rem_sel_q;
	logic [WIDTH:0]   partial;
	logic [WIDTH:0]   diff;
	logic             ge;
	logic [WIDTH-1:0] quo_fix;
	logic [WIDTH-1:0] rem_fix;

	assign neg_a = req_i.op[0] & req_i.a[WIDTH-1];
	assign neg_b = req_i.op[0] & req_i.b[WIDTH-1];
	assign mag_a = neg_a ? -req_i.a : req_i.a;
	assign mag_b = neg_b ? -req_i.b : req_i.b;

	// a negated dividend may need one bit more than its complement.
	assign steps = (no_ones_i ? CW'(1) : CW'(WIDTH) - CW'(first_one_i)) + CW'(neg_a);
	assign shift = CW'(WIDTH) - steps;

	assign partial = {rem_q, dvd_q[WIDTH-1]};
	assign ge      = (partial >= {1'b0, dvs_q});
	assign diff    = partial - {1'b0, dvs_q};

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= riscv_alu_pkg::IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				riscv_alu_pkg::IDLE: begin
					if (div_start_i) begin
						cnt_q   <= steps;
						state_q <= riscv_alu_pkg::BUSY;
					end
				end
				riscv_alu_pkg::BUSY: begin
					cnt_q <= cnt_q - CW'(1);
					if (cnt_q == CW'(1)) begin
						state_q <= riscv_alu_pkg::DONE;
					end
				end
				riscv_alu_pkg::DONE: begin
					if (out_ready_i) begin
						state_q <= riscv_alu_pkg::IDLE;
					end
				end
				default: state_q <= riscv_alu_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == riscv_alu_pkg::IDLE && div_start_i) begin
			rem_q     <= '0;
			quo_q     <= '0;
			dvd_q     <= mag_a << shift;
			dvs_q     <= mag_b;
			neg_quo_q <= neg_a ^ neg_b;
			neg_rem_q <= neg_a;
			zero_q    <= ~|req_i.b;
			rem_sel_q <= req_i.op[1];
		end else if (state_q == riscv_alu_pkg::BUSY) begin
			rem_q <= ge ? diff[WIDTH-1:0] : partial[WIDTH-1:0];
			quo_q <= {quo_q[WIDTH-2:0], ge};
			dvd_q <= dvd_q << 1;
		end
	end

	// min / -1 needs no special case, negating 2**31 wraps back to itself.
	// with a zero divisor the remainder collects the dividend unchanged.
	assign quo_fix = zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
	assign rem_fix = neg_rem_q ? -rem_q : rem_q;

	// registers do not move in DONE, so the result holds until accepted.
	assign div_result_o = rem_sel_q ? rem_fix : quo_fix;
	assign div_done_o   = (state_q == riscv_alu_pkg::DONE);

endmodule

`default_nettype wire

//--- rtl/riscv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_alu (
	input  logic                           clk_i,
	input  logic                           rst_n_i,
	input  logic                           enable_i,
	input  riscv_alu_pkg::alu_op_e         operator_i,
	input  logic [riscv_alu_pkg::XLEN-1:0] operand_a_i,
	input  logic [riscv_alu_pkg::XLEN-1:0] operand_b_i,
	input  logic                           ex_ready_i,
	output logic [riscv_alu_pkg::XLEN-1:0] result_o,
	output logic                           comparison_result_o,
	output logic                           ready_o
);

	riscv_alu_pkg::alu_req_t req;
	logic [riscv_alu_pkg::XLEN-1:0]      sum;
	logic                              cmp_true;
	logic [riscv_alu_pkg::XLEN-1:0]      minmax;
	logic [riscv_alu_pkg::XLEN-1:0]      shift_result;
	logic [riscv_alu_pkg::CNT_WIDTH-1:0] count_result;
	logic [4:0]                        first_one;
	logic                              no_ones;
	logic [riscv_alu_pkg::XLEN-1:0]      a_rev;
	logic [riscv_alu_pkg::XLEN-1:0]      a_neg_rev;
	logic [riscv_alu_pkg::XLEN-1:0]      count_in;
	logic                              is_div;
	logic                              div_start;
	logic [riscv_alu_pkg::XLEN-1:0]      div_result;
	logic                              div_done;
	logic                              div_busy_q;

	assign req = '{op: operator_i, a: operand_a_i, b: operand_b_i};

	assign a_rev     = {<<{operand_a_i}};
	assign a_neg_rev = {<<{~operand_a_i}};

	// leading zeros (or leading ones of a negative value) become a first-one search.
	always_comb begin
		count_in = '0;
		case (operator_i)
			riscv_alu_pkg::ALU_FF1:
				count_in = operand_a_i;
			riscv_alu_pkg::ALU_FL1, riscv_alu_pkg::ALU_DIVU, riscv_alu_pkg::ALU_REMU:
				count_in = a_rev;
			riscv_alu_pkg::ALU_CLB, riscv_alu_pkg::ALU_DIV, riscv_alu_pkg::ALU_REM:
				count_in = operand_a_i[riscv_alu_pkg::XLEN-1] ? a_neg_rev : a_rev;
			default: ;
		endcase
	end

	assign is_div = (operator_i == riscv_alu_pkg::ALU_DIV) ||
		(operator_i == riscv_alu_pkg::ALU_DIVU) ||
		(operator_i == riscv_alu_pkg::ALU_REM) ||
		(operator_i == riscv_alu_pkg::ALU_REMU);
	assign div_start = enable_i & is_div;

	riscv_alu_arith arith_i (
		.req_i(req), .sum_o(sum), .cmp_true_o(cmp_true), .minmax_o(minmax)
	);

	riscv_alu_shifter shifter_i (
		.req_i(req), .shift_result_o(shift_result)
	);

	riscv_alu_bit_count bit_count_i (
		.req_i(req), .count_in_i(count_in), .count_result_o(count_result),
		.first_one_o(first_one), .no_ones_o(no_ones)
	);

	riscv_alu_div #(.WIDTH(riscv_alu_pkg::XLEN)) div_i (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .div_start_i(div_start), .req_i(req),
		.first_one_i(first_one), .no_ones_i(no_ones), .out_ready_i(ex_ready_i),
		.div_result_o(div_result), .div_done_o(div_done)
	);

	always_comb begin
		result_o = '0;
		case (operator_i)
			riscv_alu_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
			riscv_alu_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
			riscv_alu_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
			riscv_alu_pkg::ALU_ADD, riscv_alu_pkg::ALU_SUB:
				result_o = sum;
			riscv_alu_pkg::ALU_SLL, riscv_alu_pkg::ALU_SRL,
			riscv_alu_pkg::ALU_SRA, riscv_alu_pkg::ALU_ROR:
				result_o = shift_result;
			riscv_alu_pkg::ALU_MIN, riscv_alu_pkg::ALU_MINU,
			riscv_alu_pkg::ALU_MAX, riscv_alu_pkg::ALU_MAXU:
				result_o = minmax;
			riscv_alu_pkg::ALU_EQ, riscv_alu_pkg::ALU_NE,
			riscv_alu_pkg::ALU_GTS, riscv_alu_pkg::ALU_GTU,
			riscv_alu_pkg::ALU_GES, riscv_alu_pkg::ALU_GEU,
			riscv_alu_pkg::ALU_LTS, riscv_alu_pkg::ALU_LTU,
			riscv_alu_pkg::ALU_LES, riscv_alu_pkg::ALU_LEU,
			riscv_alu_pkg::ALU_SLTS, riscv_alu_pkg::ALU_SLTU,
			riscv_alu_pkg::ALU_SLETS, riscv_alu_pkg::ALU_SLETU:
				result_o = {{(riscv_alu_pkg::XLEN-1){1'b0}}, cmp_true};
			riscv_alu_pkg::ALU_FF1, riscv_alu_pkg::ALU_FL1,
			riscv_alu_pkg::ALU_CNT, riscv_alu_pkg::ALU_CLB:
				result_o = {{(riscv_alu_pkg::XLEN-riscv_alu_pkg::CNT_WIDTH){1'b0}}, count_result};
			riscv_alu_pkg::ALU_DIV, riscv_alu_pkg::ALU_DIVU,
			riscv_alu_pkg::ALU_REM, riscv_alu_pkg::ALU_REMU:
				result_o = div_result;
			default: ;
		endcase
	end

	assign comparison_result_o = cmp_true;

	// high from the capture of a division until its result is taken.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			div_busy_q <= 1'b0;
		end else if (div_done && ex_ready_i) begin
			div_busy_q <= 1'b0;
		end else if (div_start) begin
			div_busy_q <= 1'b1;
		end
	end

	// ready only with the divider idle and unrequested, or holding a result.
	assign ready_o = div_done | (~div_busy_q & ~div_start);

endmodule

`default_nettype wire

//--- bench/riscv_alu_properties.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_alu_properties (
	input logic                           clk_i,
	input logic                           rst_n_i,
	input logic                           enable_i,
	input logic                           ex_ready_i,
	input logic                           div_done_i,
	input logic [riscv_alu_pkg::XLEN-1:0] result_i,
	input logic                           ready_i
);

	// with no request pending the ALU is always ready.
	idle_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!enable_i |-> ready_i)
		else $error("ready_o low while enable_i is low");

	// a finished division holds its output until the consumer takes it.
	done_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(div_done_i && !ex_ready_i) |=> ($stable(result_i) && $stable(ready_i)))
		else $error("result_o or ready_o moved while waiting for ex_ready_i");

	ready_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!$isunknown(ready_i))
		else $error("ready_o is unknown");

endmodule

bind riscv_alu riscv_alu_properties props_i (
	.clk_i(clk_i), .rst_n_i(rst_n_i), .enable_i(enable_i), .ex_ready_i(ex_ready_i),
	.div_done_i(div_done), .result_i(result_o), .ready_i(ready_o)
);

`default_nettype wire

//--- bench/riscv_alu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_alu_tb;

	localparam int CLK_PERIOD = 8;
	localparam int TIMEOUT_CYCLES = 200;
	localparam logic [31:0] SEED = 32'h546903f2;
	localparam STIM_FILE = "bench/riscv_alu_stim.txt";

	logic                           clk;
	logic                           rst_n;
	logic                           enable;
	riscv_alu_pkg::alu_op_e         operator;
	logic [riscv_alu_pkg::XLEN-1:0] operand_a;
	logic [riscv_alu_pkg::XLEN-1:0] operand_b;
	logic                           ex_ready;
	logic [riscv_alu_pkg::XLEN-1:0] result;
	logic                           comparison_result;
	logic                           ready;

	int errors;
	int group_errors;
	int group_vectors;
	int total_vectors;
	bit timed_out;

	riscv_alu dut (
		.clk_i(clk), .rst_n_i(rst_n), .enable_i(enable), .operator_i(operator),
		.operand_a_i(operand_a), .operand_b_i(operand_b), .ex_ready_i(ex_ready),
		.result_o(result), .comparison_result_o(comparison_result), .ready_o(ready)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("[FAIL] time %0d ns: %s is %h, expected %h", $time, what, got, expected);
			errors++;
			group_errors++;
		end
	endtask

	// outputs are sampled on the falling edge, away from the driving edge.
	task automatic wait_ready(output bit ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			ok = ready;
			cycles++;
		end
	endtask

	task automatic run_vector(input logic [6:0] op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] exp_res, input logic [31:0] exp_cmp);
		bit division;
		bit ok;
		int hold;
		// DIVU, DIV, REMU and REM share the upper opcode bits.
		division = (op[6:2] == 5'b01100);
		@(posedge clk);
		enable <= 1'b1;
		operator <= riscv_alu_pkg::alu_op_e'(op);
		operand_a <= a;
		operand_b <= b;
		ex_ready <= !division;
		if (division) begin
			wait_ready(ok);
		end else begin
			@(negedge clk);
			ok = 1'b1;
			check_value("ready_o", {31'b0, ready}, 32'd1);
		end
		if (!ok) begin
			$display("timeout: ready_o never rose for opcode %h", op);
			timed_out = 1'b1;
			errors++;
		end else begin
			check_value("result_o", result, exp_res);
			if (exp_cmp != 32'd2) begin
				check_value("comparison_result_o", {31'b0, comparison_result}, exp_cmp);
			end
			if (division) begin
				hold = 1 + ($urandom % 4);
				repeat (hold) begin
					@(negedge clk);
					check_value("held result_o", result, exp_res);
					check_value("held ready_o", {31'b0, ready}, 32'd1);
				end
				@(posedge clk);
				ex_ready <= 1'b1;
				// the result is taken on this edge, so the request goes away.
				@(posedge clk);
				enable <= 1'b0;
				ex_ready <= 1'b0;
			end
		end
	endtask

	task automatic report_group(input int grp);
		$display("group %0d: %0d vectors, %0d errors", grp, group_vectors, group_errors);
	endtask

	initial begin
		int fd;
		int grp;
		int cur_grp;
		string line;
		logic [7:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] exp_res;
		logic [31:0] exp_cmp;
		errors = 0;
		group_errors = 0;
		group_vectors = 0;
		total_vectors = 0;
		timed_out = 1'b0;
		void'($urandom(SEED));
		rst_n = 1'b0;
		enable = 1'b0;
		operator = riscv_alu_pkg::ALU_ADD;
		operand_a = '0;
		operand_b = '0;
		ex_ready = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		cur_grp = -1;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("could not open the stimulus file %s", STIM_FILE);
			errors++;
		end else begin
			while (!timed_out && $fgets(line, fd) != 0) begin
				if ($sscanf(line, "%h %h %h %h %h %h", grp, op, a, b, exp_res, exp_cmp) == 6) begin
					if (grp != cur_grp) begin
						if (cur_grp >= 0) begin
							report_group(cur_grp);
						end
						cur_grp = grp;
						group_errors = 0;
						group_vectors = 0;
					end
					run_vector(op[6:0], a, b, exp_res, exp_cmp);
					group_vectors++;
					total_vectors++;
				end
			end
			$fclose(fd);
			if (cur_grp >= 0) begin
				report_group(cur_grp);
			end
		end
		$display("%0d vectors run, %0d errors", total_vectors, errors);
		if (errors == 0 && total_vectors > 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- riscv_alu.f
rtl/riscv_alu_pkg.sv
rtl/riscv_alu_arith.sv
rtl/riscv_alu_shifter.sv
rtl/riscv_alu_bit_count.sv
rtl/riscv_alu_div.sv
rtl/riscv_alu.sv
bench/riscv_alu_properties.sv
bench/riscv_alu_tb.sv

//--- Bender.yml
package:
  name: riscv_alu

sources:
  - rtl/riscv_alu_pkg.sv
  - rtl/riscv_alu_arith.sv
  - rtl/riscv_alu_shifter.sv
  - rtl/riscv_alu_bit_count.sv
  - rtl/riscv_alu_div.sv
  - rtl/riscv_alu.sv
  - target: simulation
    files:
      - bench/riscv_alu_properties.sv
      - bench/riscv_alu_tb.sv

//--- bench/riscv_alu_stim.txt
# group opcode operand_a operand_b result comparison, all in hex
# a comparison value of 2 is not checked
1 18 ffffffff 00000001 00000000 2
1 18 7fffffff 00000001 80000000 2
1 19 00000003 00000005 fffffffe 2
1 15 f0f0ff00 ff00f0f0 f000f000 2
1 2e f0f0ff00 ff00f0f0 fff0fff0 2
1 2f f0f0ff00 ff00f0f0 0ff00ff0 2
2 00 ffffffff 00000001 00000001 1
2 01 ffffffff 00000001 00000000 0
2 03 00000001 ffffffff 00000001 1
2 0a 80000000 7fffffff 00000000 0
2 0b 80000000 7fffffff 00000001 1
2 0c 12345678 12345678 00000001 1
2 0d 12345678 12345678 00000000 0
2 06 00000004 00000004 00000001 1
2 08 00000004 00000005 00000000 0
2 10 ffffffff 00000001 ffffffff 2
2 11 ffffffff 00000001 00000001 2
2 12 ffffffff 00000001 00000001 2
2 13 ffffffff 00000001 ffffffff 2
3 27 80000001 00000001 00000002 2
3 27 00000001 0000001f 80000000 2
3 25 80000000 0000001f 00000001 2
3 25 80000000 00000021 40000000 2
3 24 80000000 00000001 c0000000 2
3 24 80000000 0000001f ffffffff 2
3 26 80000001 00000001 c0000000 2
3 26 12345678 00000000 12345678 2
4 36 00000000 00000000 00000020 2
4 36 00010000 00000000 00000010 2
4 37 00010000 00000000 00000010 2
4 37 ffffffff 00000000 0000001f 2
4 37 00000000 00000000 00000020 2
4 34 ffffffff 00000000 00000020 2
4 34 f0f0f0f1 00000000 00000011 2
4 35 00000000 00000000 00000000 2
4 35 ffffffff 00000000 0000001f 2
4 35 00010000 00000000 0000000e 2
4 35 fff00000 00000000 0000000b 2
5 30 00000064 00000007 0000000e 2
5 32 00000064 00000007 00000002 2
5 31 fffffff9 00000002 fffffffd 2
5 33 fffffff9 00000002 ffffffff 2
5 31 00000007 fffffffe fffffffd 2
5 30 ffffffff 00000001 ffffffff 2
5 30 00000010 00000000 ffffffff 2
5 32 00000010 00000000 00000010 2
5 33 fffffff9 00000000 fffffff9 2
5 31 80000000 ffffffff 80000000 2
5 33 80000000 ffffffff 00000000 2
6 33 7fffffff 00000003 00000001 2
6 18 00000001 00000001 00000002 2
